//--- logic/rv_pkg.sv
package rv_pkg;

    // word and register index widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // funct7 pattern that selects the M extension multiply
    localparam logic [6:0] mul_funct7 = 7'b0000001;

    // major opcodes, bits [6:0] of the instruction word
    typedef enum logic [6:0] {
        OPC_LOAD    = 7'b0000011,
        OPC_ALU_IMM = 7'b0010011,
        OPC_AUIPC   = 7'b0010111,
        OPC_STORE   = 7'b0100011,
        OPC_ALU     = 7'b0110011,
        OPC_LUI     = 7'b0110111,
        OPC_BRANCH  = 7'b1100011,
        OPC_JAL     = 7'b1101111
    } opcode_e;

    // write-back grouping, jumps count as ALU since they write rd
    typedef enum logic [2:0] {
        CLS_ALU,
        CLS_MUL,
        CLS_LOAD,
        CLS_STORE,
        CLS_NO_WB
    } instr_class_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_MUL,
        // lui result is the immediate itself
        ALU_PASS_IMM,
        // auipc sum, or the link value for jal
        ALU_PC_ADD
    } alu_op_e;

    // branch conditions carried in funct3
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

endpackage

//--- logic/dec_ex_if.sv
`timescale 1ns/1ps

// one decoded instruction, decode to execute
interface dec_ex_if import rv_pkg::*; ();

    logic                  valid;
    logic [xlen-1:0]       pc;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [xlen-1:0]       imm;
    alu_op_e               op;
    instr_class_e          iclass;
    logic [2:0]            funct3;
    logic                  is_branch;
    logic                  is_jump;
    logic                  use_imm;

    modport dec (
        output valid, pc, rd, rs1, rs2, imm, op, iclass, funct3,
               is_branch, is_jump, use_imm
    );

    modport ex (
        input valid, pc, rd, rs1, rs2, imm, op, iclass, funct3,
              is_branch, is_jump, use_imm
    );

endinterface

//--- logic/ex_wb_if.sv
`timescale 1ns/1ps

// execute result forward, register reads back
interface ex_wb_if import rv_pkg::*; ();

    logic                  valid;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       data;
    logic                  we;

    // read port addresses come from execute
    logic [reg_addr_w-1:0] rs1_addr;
    logic [reg_addr_w-1:0] rs2_addr;

    // combinational read data from the register file
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;

    modport ex (
        output valid, rd, data, we, rs1_addr, rs2_addr,
        input  rs1_data, rs2_data
    );

    modport wb (
        input  valid, rd, data, we, rs1_addr, rs2_addr,
        output rs1_data, rs2_data
    );

endinterface

//--- logic/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            instr_valid,
    input  logic [xlen-1:0] instr,
    input  logic [xlen-1:0] pc,
    dec_ex_if.dec           dx
);

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [xlen-1:0] i_imm;
    logic [xlen-1:0] s_imm;
    logic [xlen-1:0] b_imm;
    logic [xlen-1:0] u_imm;
    logic [xlen-1:0] j_imm;

    alu_op_e         op;
    instr_class_e    iclass;
    logic [xlen-1:0] imm;
    logic            is_branch;
    logic            is_jump;
    logic            use_imm;

    // funct3 to ALU op, sub only exists in the register form
    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt,
                                        input logic is_reg);
        case (f3)
            3'b000:  return (alt && is_reg) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // immediate formats, all sign extended from bit 31
    assign i_imm = {{21{instr[31]}}, instr[30:20]};
    assign s_imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm = {instr[31:12], 12'b0};
    assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        op        = ALU_ADD;
        iclass    = CLS_NO_WB;
        imm       = '0;
        is_branch = 1'b0;
        is_jump   = 1'b0;
        use_imm   = 1'b0;
        case (opcode)
            OPC_ALU: begin
                if (funct7 == mul_funct7) begin
                    op     = ALU_MUL;
                    iclass = CLS_MUL;
                end else begin
                    op     = alu_sel(funct3, funct7[5], 1'b1);
                    iclass = CLS_ALU;
                end
            end
            OPC_ALU_IMM: begin
                op      = alu_sel(funct3, funct7[5], 1'b0);
                iclass  = CLS_ALU;
                imm     = i_imm;
                use_imm = 1'b1;
            end
            OPC_LUI: begin
                op     = ALU_PASS_IMM;
                iclass = CLS_ALU;
                imm    = u_imm;
            end
            OPC_AUIPC: begin
                op     = ALU_PC_ADD;
                iclass = CLS_ALU;
                imm    = u_imm;
            end
            OPC_JAL: begin
                op      = ALU_PC_ADD;
                iclass  = CLS_ALU;
                imm     = j_imm;
                is_jump = 1'b1;
            end
            OPC_BRANCH: begin
                imm       = b_imm;
                is_branch = 1'b1;
            end
            // address math only, there is no data memory behind these
            OPC_LOAD: begin
                iclass  = CLS_LOAD;
                imm     = i_imm;
                use_imm = 1'b1;
            end
            OPC_STORE: begin
                iclass = CLS_STORE;
                imm    = s_imm;
            end
            default: begin
                iclass = CLS_NO_WB;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dx.valid <= 1'b0;
        end else begin
            dx.valid <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        dx.pc        <= pc;
        dx.rd        <= instr[11:7];
        dx.rs1       <= instr[19:15];
        dx.rs2       <= instr[24:20];
        dx.imm       <= imm;
        dx.op        <= op;
        dx.iclass    <= iclass;
        dx.funct3    <= funct3;
        dx.is_branch <= is_branch;
        dx.is_jump   <= is_jump;
        dx.use_imm   <= use_imm;
    end

endmodule

//--- logic/rv_execute.sv
`timescale 1ns/1ps

module rv_execute import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    dec_ex_if.ex            dx,
    ex_wb_if.ex             xw,
    output logic            redirect_valid,
    output logic [xlen-1:0] redirect_pc
);

    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] product;
    logic [xlen-1:0] link;
    logic [xlen-1:0] target;
    logic [xlen-1:0] result;
    logic            fwd_ok;
    logic            taken;
    logic            writes_rd;

    // register reads go straight to the register file
    assign xw.rs1_addr = dx.rs1;
    assign xw.rs2_addr = dx.rs2;

    // one-stage bypass from our own output register
    assign fwd_ok  = xw.valid && xw.we;
    assign rs1_val = (fwd_ok && xw.rd == dx.rs1) ? xw.data : xw.rs1_data;
    assign rs2_val = (fwd_ok && xw.rd == dx.rs2) ? xw.data : xw.rs2_data;

    assign op_a = rs1_val;
    assign op_b = dx.use_imm ? dx.imm : rs2_val;

    // low half of the product is the same for signed and unsigned
    assign product = op_a * op_b;

    assign link   = dx.pc + 32'd4;
    assign target = dx.pc + dx.imm;

    always_comb begin
        case (dx.op)
            ALU_ADD:      result = op_a + op_b;
            ALU_SUB:      result = op_a - op_b;
            ALU_SLL:      result = op_a << op_b[4:0];
            ALU_SLT:      result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:     result = {{(xlen-1){1'b0}}, op_a < op_b};
            ALU_XOR:      result = op_a ^ op_b;
            ALU_SRL:      result = op_a >> op_b[4:0];
            ALU_SRA:      result = $signed(op_a) >>> op_b[4:0];
            ALU_OR:       result = op_a | op_b;
            ALU_AND:      result = op_a & op_b;
            ALU_MUL:      result = product;
            ALU_PASS_IMM: result = dx.imm;
            // jal writes the return address, auipc the pc-relative sum
            ALU_PC_ADD:   result = dx.is_jump ? link : target;
            default:      result = '0;
        endcase
    end

    // branch condition, compared on the two register values
    always_comb begin
        case (dx.funct3)
            f3_beq:  taken = (rs1_val == rs2_val);
            f3_bne:  taken = (rs1_val != rs2_val);
            f3_blt:  taken = ($signed(rs1_val) < $signed(rs2_val));
            f3_bge:  taken = ($signed(rs1_val) >= $signed(rs2_val));
            f3_bltu: taken = (rs1_val < rs2_val);
            f3_bgeu: taken = (rs1_val >= rs2_val);
            default: taken = 1'b0;
        endcase
    end

    assign writes_rd = (dx.iclass == CLS_ALU || dx.iclass == CLS_MUL) && (dx.rd != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            xw.valid       <= 1'b0;
            xw.we          <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            xw.valid       <= dx.valid;
            xw.we          <= dx.valid && writes_rd;
            redirect_valid <= dx.valid && (dx.is_jump || (dx.is_branch && taken));
        end
    end

    always_ff @(posedge clk) begin
        xw.rd       <= dx.rd;
        xw.data     <= result;
        redirect_pc <= target;
    end

endmodule

//--- logic/rv_writeback.sv
`timescale 1ns/1ps

module rv_writeback import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    ex_wb_if.wb                   xw,
    output logic                  wb_valid,
    output logic [reg_addr_w-1:0] wb_rd,
    output logic [xlen-1:0]       wb_data
);

    // storage for x1 to x31 only
    logic [xlen-1:0] regs [31:1];
    logic            commit;

    assign commit = xw.valid && xw.we;

    // x0 always reads as zero
    assign xw.rs1_data = (xw.rs1_addr == '0) ? '0 : regs[xw.rs1_addr];
    assign xw.rs2_data = (xw.rs2_addr == '0) ? '0 : regs[xw.rs2_addr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (commit) begin
            regs[xw.rd] <= xw.data;
        end
    end

    // report only instructions that actually wrote a register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= commit;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= xw.rd;
        wb_data <= xw.data;
    end

endmodule

//--- logic/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  instr_valid,
    input  logic [xlen-1:0]       instr,
    input  logic [xlen-1:0]       pc,
    output logic                  wb_valid,
    output logic [reg_addr_w-1:0] wb_rd,
    output logic [xlen-1:0]       wb_data,
    output logic                  redirect_valid,
    output logic [xlen-1:0]       redirect_pc
);

    dec_ex_if dx ();
    ex_wb_if  xw ();

    rv_decoder u_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .dx          (dx.dec)
    );

    rv_execute u_execute (
        .clk            (clk),
        .rst_n          (rst_n),
        .dx             (dx.ex),
        .xw             (xw.ex),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    // register file lives in the result stage
    rv_writeback u_writeback (
        .clk      (clk),
        .rst_n    (rst_n),
        .xw       (xw.wb),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

endmodule

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);

    // 4 ns period
    initial begin
        clk = 1'b0;
    end

    always begin
        #2 clk = ~clk;
    end

endmodule

//--- bench/rv_core_assert.sv
`timescale 1ns/1ps

module rv_core_assert import rv_pkg::*; (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  wb_valid,
    input logic [reg_addr_w-1:0] wb_rd,
    input logic                  redirect_valid,
    input logic [xlen-1:0]       redirect_pc
);

    int fail_count = 0;

    // a reset edge leaves every valid output low
    reset_quiet: assert property (@(posedge clk) !rst_n |=> !wb_valid && !redirect_valid)
        else begin
            $error("valid output high after a reset edge");
            fail_count++;
        end

    // x0 never shows up as a write-back
    wb_rd_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> wb_rd != '0)
        else begin
            $error("write-back reported for x0");
            fail_count++;
        end

    // targets are always halfword aligned
    redirect_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_valid |-> !redirect_pc[0])
        else begin
            $error("redirect target has bit 0 set");
            fail_count++;
        end

endmodule

bind rv_core_top rv_core_assert u_assert (
    .clk            (clk),
    .rst_n          (rst_n),
    .wb_valid       (wb_valid),
    .wb_rd          (wb_rd),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
);

//--- bench/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core import rv_pkg::*; ();

    // words per stim line, see the header of the stim file
    localparam int fields      = 8;
    localparam int max_lines   = 64;
    localparam int drain_limit = 50;

    logic                  clk;
    logic                  rst_n;
    logic                  instr_valid;
    logic [xlen-1:0]       instr;
    logic [xlen-1:0]       pc;
    logic                  wb_valid;
    logic [reg_addr_w-1:0] wb_rd;
    logic [xlen-1:0]       wb_data;
    logic                  redirect_valid;
    logic [xlen-1:0]       redirect_pc;

    logic [31:0] stim_mem [0:fields*max_lines-1];

    // expected results, due cycle counted in rising edges
    logic [reg_addr_w-1:0] exp_wb_rd[$];
    logic [xlen-1:0]       exp_wb_data[$];
    int                    exp_wb_due[$];
    int                    exp_wb_line[$];
    logic [xlen-1:0]       exp_rdr_pc[$];
    int                    exp_rdr_due[$];
    int                    exp_rdr_line[$];

    int cycle = 0;

    tb_clock_gen u_clk (
        .clk (clk)
    );

    rv_core_top u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .pc             (pc),
        .wb_valid       (wb_valid),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare_wb(input string name,
                              input logic [reg_addr_w-1:0] exp_rd,
                              input logic [xlen-1:0] exp_data,
                              input logic [reg_addr_w-1:0] act_rd,
                              input logic [xlen-1:0] act_data);
        if (exp_rd !== act_rd) begin
            stop_run($sformatf("[FAIL] %s rd: expected %0d, actual %0d", name, exp_rd, act_rd));
        end else if (exp_data !== act_data) begin
            stop_run($sformatf("[FAIL] %s data: expected %h, actual %h",
                               name, exp_data, act_data));
        end
    endtask

    task automatic compare_redirect(input string name,
                                    input logic [xlen-1:0] exp_pc,
                                    input logic [xlen-1:0] act_pc);
        if (exp_pc !== act_pc) begin
            stop_run($sformatf("[FAIL] %s target: expected %h, actual %h", name, exp_pc, act_pc));
        end
    endtask

    // one clock slot with nothing presented
    task automatic idle_slot();
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
    endtask

    task automatic present_line(input int idx);
        int base;
        base = idx * fields;
        for (int g = 0; g < int'(stim_mem[base]); g++) begin
            idle_slot();
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b1;
        instr       = stim_mem[base+1];
        pc          = stim_mem[base+2];
        // sampled on the next edge, results follow 3 and 2 edges on from here
        if (stim_mem[base+3][0]) begin
            exp_wb_rd.push_back(stim_mem[base+4][reg_addr_w-1:0]);
            exp_wb_data.push_back(stim_mem[base+5]);
            exp_wb_due.push_back(cycle + 3);
            exp_wb_line.push_back(idx);
        end
        if (stim_mem[base+6][0]) begin
            exp_rdr_pc.push_back(stim_mem[base+7]);
            exp_rdr_due.push_back(cycle + 2);
            exp_rdr_line.push_back(idx);
        end
    endtask

    task automatic check_outputs();
        string name;
        if (exp_wb_due.size() != 0 && exp_wb_due[0] < cycle) begin
            stop_run($sformatf("write-back of stim line %0d never arrived", exp_wb_line[0]));
        end else if (exp_rdr_due.size() != 0 && exp_rdr_due[0] < cycle) begin
            stop_run($sformatf("redirect of stim line %0d never arrived", exp_rdr_line[0]));
        end else if (wb_valid && (exp_wb_due.size() == 0 || exp_wb_due[0] != cycle)) begin
            stop_run($sformatf("unexpected write-back to x%0d at cycle %0d", wb_rd, cycle));
        end else if (redirect_valid && (exp_rdr_due.size() == 0 || exp_rdr_due[0] != cycle)) begin
            stop_run($sformatf("unexpected redirect to %h at cycle %0d", redirect_pc, cycle));
        end else begin
            if (wb_valid) begin
                name = $sformatf("stim line %0d write-back", exp_wb_line[0]);
                compare_wb(name, exp_wb_rd.pop_front(), exp_wb_data.pop_front(), wb_rd, wb_data);
                void'(exp_wb_due.pop_front());
                void'(exp_wb_line.pop_front());
            end
            if (redirect_valid) begin
                name = $sformatf("stim line %0d redirect", exp_rdr_line[0]);
                compare_redirect(name, exp_rdr_pc.pop_front(), redirect_pc);
                void'(exp_rdr_due.pop_front());
                void'(exp_rdr_line.pop_front());
            end
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            check_outputs();
        end
    end

    task automatic wait_drain();
        int n;
        n = 0;
        while ((exp_wb_due.size() != 0 || exp_rdr_due.size() != 0) && n < drain_limit) begin
            @(posedge clk);
            n++;
        end
        if (exp_wb_due.size() != 0 || exp_rdr_due.size() != 0) begin
            stop_run("timed out waiting for the pipeline to drain");
        end
        // a few quiet cycles to catch stray results
        repeat (5) @(posedge clk);
    endtask

    initial begin
        int n_lines;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        $readmemh("bench/rv_stim.txt", stim_mem);
        n_lines = 0;
        while (n_lines < max_lines && !$isunknown(stim_mem[n_lines*fields+1])) begin
            n_lines++;
        end
        if (n_lines == 0) begin
            stop_run("no stimulus lines found in bench/rv_stim.txt");
        end
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < n_lines; i++) begin
            present_line(i);
        end
        idle_slot();
        wait_drain();
        if (u_dut.u_assert.fail_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Something failed");
            $fatal(1, "assertion failures were reported");
        end
    end

endmodule

//--- bench/rv_stim.txt
// gap instr pc wb_flag wb_rd wb_data redirect_flag redirect_pc
// gap is the number of idle cycles before the instruction, all values hex
0 00500093 00000100 1 01 00000005 0 00000000
0 FFD00113 00000104 1 02 FFFFFFFD 0 00000000
0 002081B3 00000108 1 03 00000002 0 00000000
0 40208233 0000010C 1 04 00000008 0 00000000
0 0020C2B3 00000110 1 05 FFFFFFF8 0 00000000
0 0020F3B3 00000114 1 07 00000005 0 00000000
0 00409413 00000118 1 08 00000050 0 00000000
0 40115493 0000011C 1 09 FFFFFFFE 0 00000000
0 01C15513 00000120 1 0A 0000000F 0 00000000
0 001125B3 00000124 1 0B 00000001 0 00000000
0 02208733 00000128 1 0E FFFFFFF1 0 00000000
0 022107B3 0000012C 1 0F 00000009 0 00000000
2 12300813 00000130 1 10 00000123 0 00000000
0 00180893 00000134 1 11 00000124 0 00000000
0 01180933 00000138 1 12 00000247 0 00000000
0 012809B3 0000013C 1 13 0000036A 0 00000000
3 01098AB3 00000140 1 15 0000048D 0 00000000
0 12345B37 00000144 1 16 12345000 0 00000000
0 00001B97 00000148 1 17 00001148 0 00000000
0 00708013 0000014C 0 00 00000000 0 00000000
0 00000C33 00000150 1 18 00000000 0 00000000
0 00708463 00000154 0 00 00000000 1 0000015C
0 00709463 00000158 0 00 00000000 0 00000000
0 FE1148E3 0000015C 0 00 00000000 1 0000014C
0 FE20C8E3 00000160 0 00 00000000 0 00000000
0 10117063 00000164 0 00 00000000 1 00000264
0 1020F063 00000168 0 00 00000000 0 00000000
0 00100CEF 0000016C 1 19 00000170 1 0000096C
0 000C8D93 00000170 1 1B 00000170 0 00000000
0 0000AE03 00000174 0 00 00000000 0 00000000
0 0020A223 00000178 0 00 00000000 0 00000000
0 00008EE7 0000017C 0 00 00000000 0 00000000
0 00000073 00000180 0 00 00000000 0 00000000

//--- tb.f
logic/rv_pkg.sv
logic/dec_ex_if.sv
logic/ex_wb_if.sv
logic/rv_decoder.sv
logic/rv_execute.sv
logic/rv_writeback.sv
logic/rv_core_top.sv
bench/tb_clock_gen.sv
bench/rv_core_assert.sv
bench/tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - logic/rv_pkg.sv
  - logic/dec_ex_if.sv
  - logic/ex_wb_if.sv
  - logic/rv_decoder.sv
  - logic/rv_execute.sv
  - logic/rv_writeback.sv
  - logic/rv_core_top.sv
  - target: test
    files:
      - bench/tb_clock_gen.sv
      - bench/rv_core_assert.sv
      - bench/tb_rv_core.sv
